// ==== dcache.f ====
rtl/dcache_pkg.sv
rtl/cache_ctl_if.sv
rtl/dcache_fsm.sv
rtl/access_counter.sv
rtl/dcache_array.sv
rtl/dcache.sv
test/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - rtl/dcache_pkg.sv
  - rtl/cache_ctl_if.sv
  - rtl/dcache_fsm.sv
  - rtl/access_counter.sv
  - rtl/dcache_array.sv
  - rtl/dcache.sv
  - target: test
    files:
      - test/dcache_tb.sv

// ==== test/dcache_tb.sv ====
module dcache_tb
	import dcache_pkg::*;
;

	// Run length limits
	localparam int NUM_REQS       = 9;
	localparam int NUM_DIRTY      = 3;
	localparam int REQ_LIMIT      = 200;
	localparam int FLUSH_LIMIT    = 20 * NUM_DIRTY + 20;
	localparam int TIMEOUT_CYCLES = NUM_REQS * REQ_LIMIT + NUM_DIRTY * 20 + 100;

	logic  CLK = 1'b0;
	logic  nRST;
	logic  halt;
	logic  dmem_ren;
	logic  dmem_wen;
	word_t dmem_addr;
	word_t dmem_store;
	logic  dhit;
	logic  flushed;
	word_t dmem_load;
	logic  d_ren;
	logic  d_wen;
	word_t d_addr;
	word_t d_store;
	logic  d_wait;
	word_t d_load;

	// Memory model state
	word_t  mem [word_t];
	word_t  written [word_t];
	int     wr_count  = 0;
	int     wait_left = 0;
	integer seed      = 32'h981c2866;

	// Scoreboard
	int errors   = 0;
	int checks   = 0;
	int tests    = 0;
	int exp_hits = 0;

	dcache uut (
		.CLK        (CLK),
		.nRST       (nRST),
		.halt       (halt),
		.dmem_ren   (dmem_ren),
		.dmem_wen   (dmem_wen),
		.dmem_addr  (dmem_addr),
		.dmem_store (dmem_store),
		.dhit       (dhit),
		.flushed    (flushed),
		.dmem_load  (dmem_load),
		.d_ren      (d_ren),
		.d_wen      (d_wen),
		.d_addr     (d_addr),
		.d_store    (d_store),
		.d_wait     (d_wait),
		.d_load     (d_load)
	);

	always #5 CLK = ~CLK;

	//////////////////////////////////////////////////
	// Memory model
	//////////////////////////////////////////////////

	// Unwritten locations, rotate and scramble the full address
	function automatic word_t model_word(input word_t a);
		return {a[7:0], a[31:8]} ^ 32'h3C5A96E1;
	endfunction

	function automatic word_t read_word(input word_t a);
		if (mem.exists(a)) begin
			return mem[a];
		end
		return model_word(a);
	endfunction

	// Wait cycles for the next transfer, 0 to 2
	function automatic int pick_wait();
		return $unsigned($random(seed)) % 3;
	endfunction

	// Transfer ends on a low wait cycle, store lands at that edge
	always @(posedge CLK) begin
		if (nRST && (d_ren || d_wen)) begin
			if (d_wait) begin
				wait_left = wait_left - 1;
			end else begin
				if (d_wen) begin
					mem[d_addr] = d_store;
					wr_count++;
				end
				wait_left = pick_wait();
			end
		end
		d_wait <= (wait_left != 0);
	end

	// Load word follows the address within the cycle
	always @(d_addr, wr_count) begin
		d_load <= read_word(d_addr);
	end

	//////////////////////////////////////////////////
	// Checks and request driver
	//////////////////////////////////////////////////

	task automatic check_word(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			$display("FAIL t=%0t %s: got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			$display("FAIL t=%0t %s: got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	function automatic word_t make_addr(input int tag, input int idx, input int blk);
		dcache_addr_t a;
		a.tag     = TAG_W'(tag);
		a.idx     = IDX_W'(idx);
		a.blkoff  = BLK_W'(blk);
		a.byteoff = '0;
		return word_t'(a);
	endfunction

	// Hold request until dhit, then drop it for one cycle
	task automatic access(input logic wr, input word_t a, input word_t wdata,
			input logic exp_hit, output word_t rdata);
		int waited;
		waited = 0;
		@(posedge CLK);
		dmem_ren   <= !wr;
		dmem_wen   <= wr;
		dmem_addr  <= a;
		dmem_store <= wdata;
		@(negedge CLK);
		check_bit("dhit", dhit, exp_hit);
		while (!dhit && waited < REQ_LIMIT) begin
			@(negedge CLK);
			waited++;
		end
		if (!dhit) begin
			$display("Request to %h got no hit within %0d cycles", a, REQ_LIMIT);
			errors++;
		end
		rdata = dmem_load;
		if (exp_hit) begin
			exp_hits++;
		end
		if (wr) begin
			written[a] = wdata;
		end
		@(posedge CLK);
		dmem_ren <= 1'b0;
		dmem_wen <= 1'b0;
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests++;
		if (errors == errs_before) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, errors - errs_before);
		end
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	task automatic reset_idle_test();
		int e;
		e = errors;
		repeat (5) begin
			@(negedge CLK);
			check_bit("dhit", dhit, 1'b0);
			check_bit("flushed", flushed, 1'b0);
			check_bit("d_ren", d_ren, 1'b0);
			check_bit("d_wen", d_wen, 1'b0);
		end
		finish_test("reset_idle", e);
	endtask

	task automatic read_miss_test();
		int    e;
		word_t a;
		word_t rdata;
		e = errors;
		a = make_addr(16, 1, 0);
		access(1'b0, a, '0, 1'b0, rdata);
		check_word("dmem_load", rdata, model_word(a));
		// Other word came in with the same fetch
		access(1'b0, a + 4, '0, 1'b1, rdata);
		check_word("dmem_load", rdata, model_word(a + 4));
		finish_test("read_miss", e);
	endtask

	task automatic write_hit_test();
		int    e;
		int    writes;
		word_t a;
		word_t rdata;
		e      = errors;
		a      = make_addr(16, 1, 0);
		writes = wr_count;
		access(1'b1, a, 32'h12345678, 1'b1, rdata);
		access(1'b0, a, '0, 1'b1, rdata);
		check_word("dmem_load", rdata, 32'h12345678);
		// Write-back cache, nothing reaches memory yet
		check_word("memory writes", word_t'(wr_count - writes), '0);
		finish_test("write_hit", e);
	endtask

	task automatic lru_writeback_test();
		int    e;
		int    writes;
		word_t a;
		word_t b;
		word_t c;
		word_t rdata;
		e = errors;
		a = make_addr(32, 2, 0);
		b = make_addr(33, 2, 0);
		c = make_addr(34, 2, 0);
		access(1'b1, a, 32'h0A0A5150, 1'b0, rdata);
		access(1'b0, b, '0, 1'b0, rdata);
		check_word("dmem_load", rdata, model_word(b));
		// B used last, so A is the victim and goes back dirty
		writes = wr_count;
		access(1'b0, c, '0, 1'b0, rdata);
		check_word("dmem_load", rdata, model_word(c));
		check_word("memory writes", word_t'(wr_count - writes), 32'd2);
		check_word("mem A word 0", read_word(a), 32'h0A0A5150);
		// Clean word matches the fill pattern, so it must also have been stored
		check_bit("mem A word 1 written", mem.exists(a + 4) != 0, 1'b1);
		check_word("mem A word 1", read_word(a + 4), model_word(a + 4));
		access(1'b0, b, '0, 1'b1, rdata);
		check_word("dmem_load", rdata, model_word(b));
		finish_test("lru_writeback", e);
	endtask

	task automatic halt_flush_test();
		int    e;
		int    waited;
		word_t d;
		word_t other;
		word_t rdata;
		e      = errors;
		waited = 0;
		d      = make_addr(48, 5, 1);
		access(1'b1, d, 32'h3C3C0505, 1'b0, rdata);
		@(posedge CLK);
		halt <= 1'b1;
		@(negedge CLK);
		while (!flushed && waited < FLUSH_LIMIT) begin
			@(negedge CLK);
			waited++;
		end
		if (!flushed) begin
			$display("flushed did not rise within %0d cycles of halt", FLUSH_LIMIT);
			errors++;
		end
		// Each written word back in memory, its partner written back unchanged
		foreach (written[a]) begin
			check_word($sformatf("mem[%h]", a), read_word(a), written[a]);
			other = a ^ 32'h4;
			if (!written.exists(other)) begin
				check_bit($sformatf("mem[%h] written", other), mem.exists(other) != 0, 1'b1);
				check_word($sformatf("mem[%h]", other), read_word(other), model_word(other));
			end
		end
		check_word("count word", read_word(COUNT_ADDR), word_t'(exp_hits));
		repeat (5) begin
			@(negedge CLK);
			check_bit("flushed", flushed, 1'b1);
			check_bit("d_ren", d_ren, 1'b0);
			check_bit("d_wen", d_wen, 1'b0);
		end
		finish_test("halt_flush", e);
	endtask

	//////////////////////////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////////////////////////

	initial begin
		nRST       = 1'b0;
		halt       = 1'b0;
		dmem_ren   = 1'b0;
		dmem_wen   = 1'b0;
		dmem_addr  = '0;
		dmem_store = '0;
		d_wait     = 1'b0;
		d_load     = '0;
		repeat (3) @(posedge CLK);
		nRST <= 1'b1;
		reset_idle_test();
		read_miss_test();
		write_hit_test();
		lru_writeback_test();
		halt_flush_test();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge CLK);
		$display("Run stopped after %0d cycles without finishing", TIMEOUT_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== rtl/dcache.sv ====
module dcache
	import dcache_pkg::*;
(
	input  logic  CLK,
	input  logic  nRST,
	// Datapath side
	input  logic  halt,
	input  logic  dmem_ren,
	input  logic  dmem_wen,
	input  word_t dmem_addr,
	input  word_t dmem_store,
	output logic  dhit,
	output logic  flushed,
	output word_t dmem_load,
	// Memory side
	output logic  d_ren,
	output logic  d_wen,
	output word_t d_addr,
	output word_t d_store,
	input  logic  d_wait,
	input  word_t d_load
);

	logic  fill_start;
	word_t count;

	// Strobes and status between FSM and array
	cache_ctl_if ctl ();

	dcache_fsm u_fsm (
		.CLK        (CLK),
		.nRST       (nRST),
		.halt       (halt),
		.d_wait     (d_wait),
		.ctl        (ctl.fsm),
		.d_ren      (d_ren),
		.d_wen      (d_wen),
		.flushed    (flushed),
		.fill_start (fill_start)
	);

	// Hit cycles minus fills
	access_counter u_counter (
		.CLK        (CLK),
		.nRST       (nRST),
		.hit        (dhit),
		.fill_start (fill_start),
		.count      (count)
	);

	dcache_array u_array (
		.CLK        (CLK),
		.nRST       (nRST),
		.ctl        (ctl.array),
		.dmem_ren   (dmem_ren),
		.dmem_wen   (dmem_wen),
		.dmem_addr  (dmem_addr),
		.dmem_store (dmem_store),
		.d_load     (d_load),
		.count      (count),
		.dhit       (dhit),
		.dmem_load  (dmem_load),
		.d_addr     (d_addr),
		.d_store    (d_store)
	);

endmodule

// ==== rtl/dcache_array.sv ====
module dcache_array
	import dcache_pkg::*;
(
	input  logic  CLK,
	input  logic  nRST,
	cache_ctl_if.array ctl,
	input  logic  dmem_ren,
	input  logic  dmem_wen,
	input  word_t dmem_addr,
	input  word_t dmem_store,
	input  word_t d_load,
	input  word_t count,
	output logic  dhit,
	output word_t dmem_load,
	output word_t d_addr,
	output word_t d_store
);

	way_t                  sets [SETS][WAYS];
	way_sel_t [SETS-1:0]   lru;
	dcache_addr_t          addr;
	logic                  req;
	logic [WAYS-1:0]       way_hit;
	way_sel_t              hit_way;
	way_sel_t              victim;
	set_way_t              scan;
	logic [IDX_W-1:0]      wb_idx;
	way_sel_t              wb_way;
	way_t                  wb_blk;

	assign addr = dcache_addr_t'(dmem_addr);
	assign req  = dmem_ren || dmem_wen;

	//////////////////////////////////////////////////
	// Tag compare and load word
	//////////////////////////////////////////////////

	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			way_hit[w] = sets[addr.idx][w].valid && (sets[addr.idx][w].tag == addr.tag);
		end
	end

	assign hit_way  = way_hit[1];
	assign dhit     = req && (|way_hit);
	assign ctl.miss = req && !(|way_hit);

	assign dmem_load = addr.blkoff[0] ? sets[addr.idx][hit_way].word2
		: sets[addr.idx][hit_way].word1;

	// LRU way of the addressed set gets replaced
	assign victim           = lru[addr.idx];
	assign ctl.victim_dirty = sets[addr.idx][victim].dirty;

	//////////////////////////////////////////////////
	// Storage and LRU update
	//////////////////////////////////////////////////

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			lru <= '0;
			for (int s = 0; s < SETS; s++) begin
				for (int w = 0; w < WAYS; w++) begin
					sets[s][w].valid <= 1'b0;
					sets[s][w].dirty <= 1'b0;
				end
			end
		end else begin
			// Any hit makes the other way least recent
			if (dhit) begin
				lru[addr.idx] <= !hit_way;
			end
			// Write hit, block turns dirty
			if (dhit && dmem_wen) begin
				sets[addr.idx][hit_way].dirty <= 1'b1;
				if (addr.blkoff[0]) begin
					sets[addr.idx][hit_way].word2 <= dmem_store;
				end else begin
					sets[addr.idx][hit_way].word1 <= dmem_store;
				end
			end
			// Fill into the victim, block only valid once word 2 is in
			if (ctl.fill) begin
				if (ctl.word_sel) begin
					sets[addr.idx][victim].word2 <= d_load;
					sets[addr.idx][victim].tag   <= addr.tag;
					sets[addr.idx][victim].valid <= 1'b1;
					sets[addr.idx][victim].dirty <= 1'b0;
				end else begin
					sets[addr.idx][victim].word1 <= d_load;
					sets[addr.idx][victim].valid <= 1'b0;
				end
			end
			// Writeback done for the selected block
			if (ctl.clean) begin
				sets[wb_idx][wb_way].dirty <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////
	// Dirty scan, highest block wins
	//////////////////////////////////////////////////

	always_comb begin
		scan           = '0;
		ctl.some_dirty = 1'b0;
		for (int s = 0; s < SETS; s++) begin
			for (int w = 0; w < WAYS; w++) begin
				if (sets[s][w].dirty) begin
					scan           = set_way_t'{idx: IDX_W'(s), way: way_sel_t'(w)};
					ctl.some_dirty = 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Memory address and store word
	//////////////////////////////////////////////////

	// Writeback source: scanned block in a flush, victim otherwise
	assign wb_idx = ctl.flush_sel ? scan.idx : addr.idx;
	assign wb_way = ctl.flush_sel ? scan.way : victim;
	assign wb_blk = sets[wb_idx][wb_way];

	always_comb begin
		d_addr  = BAD_WORD;
		d_store = BAD_WORD;
		if (ctl.count_sel) begin
			d_addr  = COUNT_ADDR;
			d_store = count;
		end else if (ctl.flush_sel || (ctl.miss && ctl.victim_dirty)) begin
			d_addr  = dcache_addr_t'{tag: wb_blk.tag, idx: wb_idx,
				blkoff: ctl.word_sel, byteoff: '0};
			d_store = ctl.word_sel ? wb_blk.word2 : wb_blk.word1;
		end else if (ctl.miss) begin
			// Fetch of the requested block
			d_addr  = dcache_addr_t'{tag: addr.tag, idx: addr.idx,
				blkoff: ctl.word_sel, byteoff: '0};
		end
	end

endmodule

// ==== rtl/access_counter.sv ====
module access_counter
	import dcache_pkg::*;
(
	input  logic  CLK,
	input  logic  nRST,
	input  logic  hit,
	input  logic  fill_start,
	output word_t count
);

	word_t hit_cnt;
	word_t fill_cnt;

	// Every cycle with dhit high
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			hit_cnt <= '0;
		end else if (hit) begin
			hit_cnt <= hit_cnt + 1'b1;
		end
	end

	// Every block fetch
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			fill_cnt <= '0;
		end else if (fill_start) begin
			fill_cnt <= fill_cnt + 1'b1;
		end
	end

	// A missed request still ends with one hit cycle
	assign count = hit_cnt - fill_cnt;

endmodule

// ==== rtl/dcache_fsm.sv ====
module dcache_fsm
	import dcache_pkg::*;
(
	input  logic CLK,
	input  logic nRST,
	input  logic halt,
	input  logic d_wait,
	cache_ctl_if.fsm ctl,
	output logic d_ren,
	output logic d_wen,
	output logic flushed,
	output logic fill_start
);

	state_t state;
	state_t next_state;
	logic   xfer_done;

	// Memory finishes a transfer when wait drops
	assign xfer_done = !d_wait;

	//////////////////////////////////////////////////
	// State register
	//////////////////////////////////////////////////

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	//////////////////////////////////////////////////
	// Next state
	//////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				// Miss first, a hit just stays here
				if (ctl.miss) begin
					next_state = ctl.victim_dirty ? WB1 : FD1;
				end else if (halt) begin
					next_state = DCHK;
				end
			end
			// Victim writeback, then fetch
			WB1:     if (xfer_done) next_state = WB2;
			WB2:     if (xfer_done) next_state = FD1;
			FD1:     if (xfer_done) next_state = FD2;
			FD2:     if (xfer_done) next_state = IDLE;
			DCHK: begin
				// Scan result already reflects the last cleaned block
				next_state = ctl.some_dirty ? WBD1 : WRCNT;
			end
			WBD1:    if (xfer_done) next_state = WBD2;
			WBD2:    if (xfer_done) next_state = DCHK;
			WRCNT:   if (xfer_done) next_state = FLUSHED;
			// Held until reset
			FLUSHED: next_state = FLUSHED;
			default: next_state = IDLE;
		endcase
	end

	//////////////////////////////////////////////////
	// Outputs decoded from state
	//////////////////////////////////////////////////

	// Memory strobes
	assign d_ren = (state == FD1) || (state == FD2);
	assign d_wen = (state == WB1) || (state == WB2) || (state == WBD1) ||
		(state == WBD2) || (state == WRCNT);

	// Second word of a block
	assign ctl.word_sel = (state == WB2) || (state == FD2) || (state == WBD2);

	// Flush path uses the dirty scan instead of the victim
	assign ctl.flush_sel = (state == DCHK) || (state == WBD1) || (state == WBD2);
	assign ctl.count_sel = (state == WRCNT);

	// Fetched word lands in the array this cycle
	assign ctl.fill = d_ren && xfer_done;

	// Both words of the block are back in memory
	assign ctl.clean = ((state == WB2) || (state == WBD2)) && xfer_done;

	assign flushed = (state == FLUSHED);

	// One pulse per block fetch
	assign fill_start = (next_state == FD1) && (state != FD1);

endmodule

// ==== rtl/cache_ctl_if.sv ====
interface cache_ctl_if;

	// Strobes from the state machine
	logic fill;
	logic word_sel;
	logic flush_sel;
	logic clean;
	logic count_sel;

	// Status from the array
	logic miss;
	logic victim_dirty;
	logic some_dirty;

	modport fsm (
		output fill, word_sel, flush_sel, clean, count_sel,
		input  miss, victim_dirty, some_dirty
	);

	modport array (
		input  fill, word_sel, flush_sel, clean, count_sel,
		output miss, victim_dirty, some_dirty
	);

endinterface

// ==== rtl/dcache_pkg.sv ====
package dcache_pkg;

	//////////////////////////////////////////////////
	// Words and address layout
	//////////////////////////////////////////////////

	typedef logic [31:0] word_t;

	// Field widths, high bits to low bits
	localparam int TAG_W  = 26;
	localparam int IDX_W  = 3;
	localparam int BLK_W  = 1;
	localparam int BYTE_W = 2;

	typedef struct packed {
		logic [TAG_W-1:0]  tag;
		logic [IDX_W-1:0]  idx;
		logic [BLK_W-1:0]  blkoff;
		logic [BYTE_W-1:0] byteoff;
	} dcache_addr_t;

	//////////////////////////////////////////////////
	// Geometry and storage entries
	//////////////////////////////////////////////////

	localparam int SETS = 8;
	localparam int WAYS = 2;

	// One way of a set, word1 is block offset 0
	typedef struct packed {
		logic             valid;
		logic             dirty;
		logic [TAG_W-1:0] tag;
		word_t            word1;
		word_t            word2;
	} way_t;

	// Way number, 0 is way 1
	typedef logic way_sel_t;

	// Names one block in the cache
	typedef struct packed {
		logic [IDX_W-1:0] idx;
		way_sel_t         way;
	} set_way_t;

	// Controller states
	typedef enum logic [3:0] {
		IDLE    = 4'h1,
		WB1     = 4'h2,
		WB2     = 4'h3,
		FD1     = 4'h4,
		FD2     = 4'h5,
		WBD1    = 4'h6,
		WBD2    = 4'h7,
		DCHK    = 4'h8,
		WRCNT   = 4'hA,
		FLUSHED = 4'hB
	} state_t;

	// Count word destination after a flush
	localparam word_t COUNT_ADDR = 32'h00003100;
	// Marker on the memory bus when nothing is selected
	localparam word_t BAD_WORD   = 32'hECE43700;

endpackage
